//--- boardPkg.sv
package boardPkg;

    // ####################
    // Board geometry

    localparam int BoardCols = 10;
    // Four hidden spawn rows sit above the 20 visible ones
    localparam int BoardRows = 24;
    localparam int HiddenRows = 4;
    localparam int VisibleCells = 200;

    localparam int RowW = 5;
    localparam int ColW = 4;

    // ####################
    // Game constants

    // Gravity interval in clock cycles
    localparam int DropPeriod = 32;

    localparam int LineScore = 10;
    localparam int PieceScore = 1;
    localparam int ScoreW = 7;

endpackage

//--- piecePkg.sv
package piecePkg;

    localparam int TypeW = 3;
    localparam int RotW = 2;
    localparam int KeyW = 2;
    localparam int OffW = 3;

    localparam logic [TypeW-1:0] PieceI = 3'd0;
    localparam logic [TypeW-1:0] PieceO = 3'd1;
    localparam logic [TypeW-1:0] PieceT = 3'd2;
    localparam logic [TypeW-1:0] PieceL = 3'd3;
    localparam logic [TypeW-1:0] PieceS = 3'd4;
    localparam int NumPieces = 5;

    localparam logic [KeyW-1:0] KeyNone = 2'b00;
    localparam logic [KeyW-1:0] KeyLeft = 2'b01;
    localparam logic [KeyW-1:0] KeyRight = 2'b10;
    localparam logic [KeyW-1:0] KeyRotate = 2'b11;

    // Center of a freshly spawned piece
    localparam int SpawnCol = 5;
    localparam int SpawnRow = 2;

    // Column and row offsets of the four cells around the center
    function automatic void shapeOffsets(
        input  logic [TypeW-1:0]       pType,
        input  logic [RotW-1:0]        rot,
        output logic signed [OffW-1:0] dc [4],
        output logic signed [OffW-1:0] dr [4]
    );
        dc = '{0, 0, 0, 0};
        dr = '{0, 0, 0, 0};
        case (pType)
            PieceI: begin
                if (rot[0]) begin
                    dr = '{-2, -1, 0, 1};
                end else begin
                    dc = '{-2, -1, 0, 1};
                end
            end
            PieceO: begin
                dc = '{0, 1, 0, 1};
                dr = '{0, 0, -1, -1};
            end
            PieceT: begin
                case (rot)
                    2'd0: begin
                        dc = '{-1, 0, 1, 0};
                        dr = '{0, 0, 0, -1};
                    end
                    2'd1: begin
                        dc = '{0, 0, 0, 1};
                        dr = '{-1, 0, 1, 0};
                    end
                    2'd2: begin
                        dc = '{-1, 0, 1, 0};
                        dr = '{0, 0, 0, 1};
                    end
                    default: begin
                        dc = '{0, 0, 0, -1};
                        dr = '{-1, 0, 1, 0};
                    end
                endcase
            end
            PieceL: begin
                case (rot)
                    2'd0: begin
                        dc = '{-1, 0, 1, 1};
                        dr = '{0, 0, 0, -1};
                    end
                    2'd1: begin
                        dc = '{0, 0, 0, 1};
                        dr = '{-1, 0, 1, 1};
                    end
                    2'd2: begin
                        dc = '{-1, 0, 1, -1};
                        dr = '{0, 0, 0, 1};
                    end
                    default: begin
                        dc = '{0, 0, 0, -1};
                        dr = '{-1, 0, 1, -1};
                    end
                endcase
            end
            PieceS: begin
                case (rot)
                    2'd0: begin
                        dc = '{-1, 0, 0, 1};
                        dr = '{0, 0, -1, -1};
                    end
                    2'd1: begin
                        dc = '{0, -1, -1, 0};
                        dr = '{0, 0, -1, 1};
                    end
                    2'd2: begin
                        dc = '{0, 1, -1, 0};
                        dr = '{0, 0, -1, -1};
                    end
                    default: begin
                        dc = '{0, -1, 0, -1};
                        dr = '{0, 0, -1, 1};
                    end
                endcase
            end
            default: begin
                dc = '{0, 0, 0, 0};
            end
        endcase
    endfunction

endpackage

//--- dropTimer.sv
module dropTimer import boardPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic tick
);

    logic [$clog2(DropPeriod)-1:0] count;

    assign tick = run && (count == DropPeriod - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else if (run) begin
            count <= count + 1'b1;
        end
    end

    // Ticks are spaced by at least one full period of run cycles
    assert property (@(posedge clk) disable iff (rst)
        tick |=> (!tick) [*DropPeriod-1]);

endmodule

//--- pieceUnit.sv
module pieceUnit import boardPkg::*, piecePkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             moveStrobe,
    input  logic [KeyW-1:0]  moveCmd,
    input  logic             dropStrobe,
    input  logic             spawnStrobe,
    input  logic [TypeW-1:0] spawnType,
    output logic [RowW-1:0]  curRows [4],
    output logic [ColW-1:0]  curCols [4],
    output logic [RowW-1:0]  prevRows [4],
    output logic [ColW-1:0]  prevCols [4],
    output logic [3:0]       probeMask,
    output logic             inHidden
);

    logic [ColW-1:0]        cenCol;
    logic [RowW-1:0]        cenRow;
    logic [RotW-1:0]        rot;
    logic [TypeW-1:0]       pType;
    logic [ColW-1:0]        prevCol;
    logic [RowW-1:0]        prevRow;
    logic [RotW-1:0]        prevRot;
    logic [RotW-1:0]        candRot;
    int                     candCol;
    int                     candRow;
    logic                   legal;
    logic signed [OffW-1:0] candDc [4];
    logic signed [OffW-1:0] candDr [4];
    logic signed [OffW-1:0] curDc [4];
    logic signed [OffW-1:0] curDr [4];
    logic signed [OffW-1:0] prvDc [4];
    logic signed [OffW-1:0] prvDr [4];

    // ####################
    // Candidate placement

    always_comb begin
        candCol = int'(cenCol);
        candRow = int'(cenRow);
        candRot = rot;
        if (moveStrobe) begin
            case (moveCmd)
                KeyLeft: candCol = candCol - 1;
                KeyRight: candCol = candCol + 1;
                KeyRotate: candRot = rot + 1'b1;
                default: candRot = rot;
            endcase
        end else if (dropStrobe) begin
            candRow = candRow + 1;
        end
        shapeOffsets(pType, candRot, candDc, candDr);
        // Only the walls and the floor limit a move
        legal = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (candCol + int'(candDc[i]) < 0 || candCol + int'(candDc[i]) >= BoardCols ||
                candRow + int'(candDr[i]) < 0 || candRow + int'(candDr[i]) >= BoardRows) begin
                legal = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pType <= PieceI;
            cenCol <= ColW'(SpawnCol);
            cenRow <= RowW'(SpawnRow);
            rot <= '0;
            prevCol <= ColW'(SpawnCol);
            prevRow <= RowW'(SpawnRow);
            prevRot <= '0;
        end else if (spawnStrobe) begin
            pType <= spawnType;
            cenCol <= ColW'(SpawnCol);
            cenRow <= RowW'(SpawnRow);
            rot <= '0;
            prevCol <= ColW'(SpawnCol);
            prevRow <= RowW'(SpawnRow);
            prevRot <= '0;
        end else if (moveStrobe || dropStrobe) begin
            prevCol <= cenCol;
            prevRow <= cenRow;
            prevRot <= rot;
            if (legal) begin
                cenCol <= ColW'(candCol);
                cenRow <= RowW'(candRow);
                rot <= candRot;
            end
        end
    end

    // ####################
    // Cell coordinates

    always_comb begin
        shapeOffsets(pType, rot, curDc, curDr);
        shapeOffsets(pType, prevRot, prvDc, prvDr);
        for (int i = 0; i < 4; i++) begin
            curCols[i] = ColW'(int'(cenCol) + int'(curDc[i]));
            curRows[i] = RowW'(int'(cenRow) + int'(curDr[i]));
            prevCols[i] = ColW'(int'(prevCol) + int'(prvDc[i]));
            prevRows[i] = RowW'(int'(prevRow) + int'(prvDr[i]));
        end
    end

    // A cell directly below one of our own cells is not probed
    always_comb begin
        inHidden = 1'b0;
        for (int i = 0; i < 4; i++) begin
            probeMask[i] = 1'b1;
            if (curRows[i] < HiddenRows) begin
                inHidden = 1'b1;
            end
            for (int j = 0; j < 4; j++) begin
                if (curCols[j] == curCols[i] && int'(curRows[j]) == int'(curRows[i]) + 1) begin
                    probeMask[i] = 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        curCols[0] < BoardCols && curCols[1] < BoardCols &&
        curCols[2] < BoardCols && curCols[3] < BoardCols);

endmodule

//--- boardStore.sv
module boardStore import boardPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    eraseEn,
    input  logic                    drawEn,
    input  logic [RowW-1:0]         prevRows [4],
    input  logic [ColW-1:0]         prevCols [4],
    input  logic [RowW-1:0]         curRows [4],
    input  logic [ColW-1:0]         curCols [4],
    input  logic [3:0]              probeMask,
    input  logic [RowW-1:0]         scanRow,
    input  logic                    collapseEn,
    output logic                    landHit,
    output logic                    rowFull,
    output logic [VisibleCells-1:0] objects
);

    // Row 0 is the top hidden row
    logic [BoardCols-1:0] cells [BoardRows];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < BoardRows; r++) begin
                cells[r] <= '0;
            end
        end else if (collapseEn) begin
            for (int r = BoardRows - 1; r > 0; r--) begin
                if (r <= int'(scanRow)) begin
                    cells[r] <= cells[r - 1];
                end
            end
            cells[0] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (eraseEn) begin
                    cells[prevRows[i]][prevCols[i]] <= 1'b0;
                end
                if (drawEn) begin
                    cells[curRows[i]][curCols[i]] <= 1'b1;
                end
            end
        end
    end

    // ####################
    // Probes

    // The row past the bottom counts as solid floor
    always_comb begin
        landHit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (probeMask[i]) begin
                if (int'(curRows[i]) == BoardRows - 1) begin
                    landHit = 1'b1;
                end else if (cells[curRows[i] + 1'b1][curCols[i]]) begin
                    landHit = 1'b1;
                end
            end
        end
    end

    assign rowFull = &cells[scanRow];

    always_comb begin
        for (int r = HiddenRows; r < BoardRows; r++) begin
            objects[(r - HiddenRows) * BoardCols +: BoardCols] = cells[r];
        end
    end

    // At most one write source per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({eraseEn, drawEn, collapseEn}));

endmodule

//--- gameFsm.sv
module gameFsm import boardPkg::*, piecePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [KeyW-1:0]   key,
    input  logic              tick,
    input  logic              landHit,
    input  logic              rowFull,
    input  logic              inHidden,
    output logic              timerRun,
    output logic              moveStrobe,
    output logic [KeyW-1:0]   moveCmd,
    output logic              dropStrobe,
    output logic              spawnStrobe,
    output logic [TypeW-1:0]  spawnType,
    output logic              eraseEn,
    output logic              drawEn,
    output logic [RowW-1:0]   scanRow,
    output logic              collapseEn,
    output logic [ScoreW-1:0] score,
    output logic [TypeW-1:0]  nextBlock,
    output logic              fail
);

    localparam logic [2:0] Idle = 3'd0;
    localparam logic [2:0] Erase = 3'd1;
    localparam logic [2:0] Draw = 3'd2;
    localparam logic [2:0] Check = 3'd3;
    localparam logic [2:0] Scan = 3'd4;
    localparam logic [2:0] Spawn = 3'd5;
    localparam logic [2:0] Over = 3'd6;

    logic [2:0]      state;
    logic [KeyW-1:0] pendKey;
    logic            landed;
    logic            serveKey;

    // ####################
    // Strobes

    // Keys and gravity no longer move a landed piece
    always_comb begin
        serveKey = (state == Idle) && (pendKey != KeyNone);
        timerRun = (state == Idle) && !serveKey;
        moveStrobe = serveKey && !landed;
        moveCmd = pendKey;
        dropStrobe = tick && !landed;
        spawnStrobe = (state == Spawn);
        spawnType = nextBlock;
        eraseEn = (state == Erase);
        drawEn = (state == Draw);
        collapseEn = (state == Scan) && rowFull;
    end

    // ####################
    // Sequencing

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            pendKey <= KeyNone;
            landed <= 1'b0;
            scanRow <= RowW'(BoardRows - 1);
            score <= '0;
            nextBlock <= PieceI;
            fail <= 1'b0;
        end else begin
            // Latest key wins
            if (state != Over && key != KeyNone) begin
                pendKey <= key;
            end else if (serveKey) begin
                pendKey <= KeyNone;
            end

            case (state)
                Idle: begin
                    if (moveStrobe || dropStrobe) begin
                        state <= Erase;
                    end else if (tick) begin
                        state <= Spawn;
                    end
                end
                Spawn: begin
                    score <= score + ScoreW'(PieceScore);
                    if (nextBlock == NumPieces - 1) begin
                        nextBlock <= PieceI;
                    end else begin
                        nextBlock <= nextBlock + 1'b1;
                    end
                    landed <= 1'b0;
                    state <= Erase;
                end
                Erase: state <= Draw;
                Draw: state <= Check;
                Check: begin
                    if (!landHit) begin
                        state <= Idle;
                    end else if (inHidden) begin
                        fail <= 1'b1;
                        state <= Over;
                    end else begin
                        landed <= 1'b1;
                        scanRow <= RowW'(BoardRows - 1);
                        state <= Scan;
                    end
                end
                Scan: begin
                    // Stay on a collapsed row since the row above moves into it
                    if (rowFull) begin
                        score <= score + ScoreW'(LineScore);
                    end else if (scanRow == HiddenRows) begin
                        state <= Idle;
                    end else begin
                        scanRow <= scanRow - 1'b1;
                    end
                end
                default: state <= Over;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fail |-> (state == Over) ##1 fail);

endmodule

//--- tetrisTop.sv
module tetrisTop import boardPkg::*, piecePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [KeyW-1:0]         key,
    output logic [ScoreW-1:0]       score,
    output logic [TypeW-1:0]        nextBlock,
    output logic [VisibleCells-1:0] objects,
    output logic                    fail
);

    logic             timerRun;
    logic             tick;
    logic             moveStrobe;
    logic [KeyW-1:0]  moveCmd;
    logic             dropStrobe;
    logic             spawnStrobe;
    logic [TypeW-1:0] spawnType;
    logic [RowW-1:0]  curRows [4];
    logic [ColW-1:0]  curCols [4];
    logic [RowW-1:0]  prevRows [4];
    logic [ColW-1:0]  prevCols [4];
    logic [3:0]       probeMask;
    logic             inHidden;
    logic             eraseEn;
    logic             drawEn;
    logic [RowW-1:0]  scanRow;
    logic             collapseEn;
    logic             landHit;
    logic             rowFull;

    dropTimer uTimer (
        .clk  (clk),
        .rst  (rst),
        .run  (timerRun),
        .tick (tick)
    );

    pieceUnit uPiece (
        .clk         (clk),
        .rst         (rst),
        .moveStrobe  (moveStrobe),
        .moveCmd     (moveCmd),
        .dropStrobe  (dropStrobe),
        .spawnStrobe (spawnStrobe),
        .spawnType   (spawnType),
        .curRows     (curRows),
        .curCols     (curCols),
        .prevRows    (prevRows),
        .prevCols    (prevCols),
        .probeMask   (probeMask),
        .inHidden    (inHidden)
    );

    boardStore uBoard (
        .clk        (clk),
        .rst        (rst),
        .eraseEn    (eraseEn),
        .drawEn     (drawEn),
        .prevRows   (prevRows),
        .prevCols   (prevCols),
        .curRows    (curRows),
        .curCols    (curCols),
        .probeMask  (probeMask),
        .scanRow    (scanRow),
        .collapseEn (collapseEn),
        .landHit    (landHit),
        .rowFull    (rowFull),
        .objects    (objects)
    );

    gameFsm uFsm (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .tick        (tick),
        .landHit     (landHit),
        .rowFull     (rowFull),
        .inHidden    (inHidden),
        .timerRun    (timerRun),
        .moveStrobe  (moveStrobe),
        .moveCmd     (moveCmd),
        .dropStrobe  (dropStrobe),
        .spawnStrobe (spawnStrobe),
        .spawnType   (spawnType),
        .eraseEn     (eraseEn),
        .drawEn      (drawEn),
        .scanRow     (scanRow),
        .collapseEn  (collapseEn),
        .score       (score),
        .nextBlock   (nextBlock),
        .fail        (fail)
    );

endmodule

//--- tetrisTop_tb.sv
module tetrisTop_tb import boardPkg::*, piecePkg::*; ();

    // Conditions that waitFor can poll
    localparam int CondScore = 0;
    localparam int CondFail = 1;
    localparam int CondShown = 2;
    localparam int CondCleared = 3;

    logic                    clk;
    logic                    rst;
    logic [KeyW-1:0]         key;
    logic [ScoreW-1:0]       score;
    logic [TypeW-1:0]        nextBlock;
    logic [VisibleCells-1:0] objects;
    logic                    fail;

    int    errorCount;
    int    startErrors;
    int    testCount;
    int    failedTests;
    string curTest;

    tetrisTop uut (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .score     (score),
        .nextBlock (nextBlock),
        .objects   (objects),
        .fail      (fail)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ####################
    // Helpers

    // Expected board bits for columns firstCol..lastCol of one row
    function automatic logic [VisibleCells-1:0] rowCells(input int row, input int firstCol,
                                                         input int lastCol);
        logic [VisibleCells-1:0] mask;
        mask = '0;
        for (int c = firstCol; c <= lastCol; c++) begin
            mask[(row - 4) * 10 + c] = 1'b1;
        end
        return mask;
    endfunction

    function automatic logic condHolds(input int kind, input int value);
        case (kind)
            CondScore: return int'(score) == value;
            CondFail: return fail === 1'b1;
            CondShown: return objects != '0;
            default: begin
                return ((objects & rowCells(23, 0, 9)) == rowCells(23, 4, 5)) &&
                       ((objects & rowCells(22, 0, 9)) == '0);
            end
        endcase
    endfunction

    task automatic check(input string what, input logic [VisibleCells-1:0] expected,
                         input logic [VisibleCells-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", curTest, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic waitFor(input int kind, input int value, input int limit, input string what);
        int n;
        n = 0;
        while (!condHolds(kind, value) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!condHolds(kind, value)) begin
            $display("%s: gave up after %0d cycles waiting for %s", curTest, limit, what);
            errorCount++;
        end
    endtask

    // One cycle of key, then six quiet cycles
    task automatic pressKey(input logic [KeyW-1:0] code);
        @(negedge clk);
        key = code;
        @(negedge clk);
        key = KeyNone;
        repeat (6) @(negedge clk);
    endtask

    task automatic resetDut();
        @(negedge clk);
        rst = 1'b1;
        key = KeyNone;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic startTest(input string name);
        curTest = name;
        startErrors = errorCount;
        resetDut();
    endtask

    task automatic finishTest();
        testCount++;
        if (errorCount > startErrors) begin
            failedTests++;
            $display("%s: fail", curTest);
        end else begin
            $display("%s: pass", curTest);
        end
    endtask

    // ####################
    // Tests

    task automatic resetState();
        startTest("reset");
        check("objects", '0, objects);
        check("score", '0, score);
        check("nextBlock", '0, nextBlock);
        check("fail", '0, fail);
        waitFor(CondShown, 0, 200, "the first piece to show");
        check("first piece", rowCells(4, 3, 6), objects);
        finishTest();
    endtask

    task automatic leftWall();
        startTest("leftWall");
        repeat (5) pressKey(KeyLeft);
        waitFor(CondScore, 1, 2000, "the piece to land");
        check("objects", rowCells(23, 0, 3), objects);
        check("nextBlock", 1, nextBlock);
        finishTest();
    endtask

    task automatic rightWall();
        startTest("rightWall");
        repeat (5) pressKey(KeyRight);
        waitFor(CondScore, 1, 2000, "the piece to land");
        check("objects", rowCells(23, 6, 9), objects);
        finishTest();
    endtask

    task automatic rotateDrop();
        logic [VisibleCells-1:0] column;
        startTest("rotate");
        column = rowCells(20, 5, 5) | rowCells(21, 5, 5) | rowCells(22, 5, 5) |
                 rowCells(23, 5, 5);
        pressKey(KeyRotate);
        waitFor(CondScore, 1, 2000, "the piece to land");
        check("objects", column, objects);
        finishTest();
    endtask

    task automatic rowClear();
        startTest("rowClear");
        repeat (3) pressKey(KeyLeft);
        waitFor(CondScore, 1, 2000, "the first piece to land");
        repeat (3) pressKey(KeyRight);
        waitFor(CondScore, 2, 2000, "the second piece to land");
        // The O fills the gap in columns 4 and 5
        pressKey(KeyLeft);
        waitFor(CondCleared, 0, 2000, "the bottom row to clear");
        check("objects", rowCells(23, 4, 5), objects);
        check("score", 12, score);
        finishTest();
    endtask

    task automatic gameOver();
        logic [VisibleCells-1:0] savedObjects;
        logic [ScoreW-1:0]       savedScore;
        startTest("gameOver");
        waitFor(CondFail, 0, 60000, "the stack to reach the hidden rows");
        savedObjects = objects;
        savedScore = score;
        pressKey(KeyLeft);
        pressKey(KeyRight);
        pressKey(KeyRotate);
        repeat (300) @(negedge clk);
        check("objects frozen", savedObjects, objects);
        check("score frozen", savedScore, score);
        check("fail held", 1, fail);
        finishTest();
    endtask

    // ####################
    // Sequence

    initial begin
        rst = 1'b1;
        key = KeyNone;
        errorCount = 0;
        startErrors = 0;
        testCount = 0;
        failedTests = 0;
        curTest = "";
        resetState();
        leftWall();
        rightWall();
        rotateDrop();
        rowClear();
        gameOver();
        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tetrisTop.f
boardPkg.sv
piecePkg.sv
dropTimer.sv
pieceUnit.sv
boardStore.sv
gameFsm.sv
tetrisTop.sv
tetrisTop_tb.sv
